// File: Bender.yml
package:
  name: psx_slots

sources:
  - psx_bus_pkg.sv
  - psx_state_pkg.sv
  - psx_slot_port.sv
  - psx_slot_mux.sv
  - psx_state_ram.sv
  - psx_port_scanner.sv
  - psx_slot_hub.sv
  - target: test
    files:
      - tb_psx_slot_hub.sv

// File: psx_bus_pkg.sv
// slot pin, serial flag and host bus types

package psx_bus_pkg;

    // number of emulated controller slots.
    localparam int num_ports = 4;

    // a slot number.
    typedef logic [1:0] port_t;

    // raw slot pins, one bit per slot in each vector.
    typedef struct packed {
        logic [num_ports-1:0] sel;
        logic [num_ports-1:0] sclk;
        logic [num_ports-1:0] cmd;
    } slot_pins_t;

    // sticky flags and the latched command bit of the selected slot.
    typedef struct packed {
        logic begin_flag;
        logic cmd_avail;
        logic cmd_data;
        logic reply_ready;
    } ssp_status_t;

    // requests from the scanner to the selected slot.
    typedef struct packed {
        logic clear;
        logic reply_data;
        logic reply_strobe;
    } ssp_ctrl_t;

    // host request, held stable until done.
    typedef struct packed {
        port_t      port;
        logic       read;
        logic       write;
        logic [7:0] reply;
    } ppb_req_t;

    // host response, command and index only mean something on a read.
    typedef struct packed {
        logic       done;
        logic [7:0] command;
        logic [4:0] index;
    } ppb_rsp_t;

endpackage

// File: psx_port_scanner.sv
// port scanner and host handshake

module psx_port_scanner (
    input  logic                               clk,
    input  logic                               reset,
    input  psx_bus_pkg::ssp_status_t           status,
    input  psx_bus_pkg::ppb_req_t              req,
    output psx_bus_pkg::port_t                 cur_port,
    output psx_bus_pkg::ssp_ctrl_t             ctrl,
    output psx_state_pkg::state_addr_t         mem_addr,
    output logic                               mem_wr,
    output logic [15:0]                        mem_wdata,
    input  logic [15:0]                        mem_rdata,
    output logic [psx_bus_pkg::num_ports-1:0]  irq_flags,
    output psx_bus_pkg::ppb_rsp_t              rsp
);

    psx_state_pkg::scan_state_t state;
    psx_state_pkg::scan_state_t next_visit;
    psx_state_pkg::cmd_word_t   cmd_rd;
    psx_state_pkg::cmd_word_t   cmd_wr;
    psx_state_pkg::reply_word_t rep_rd;
    psx_state_pkg::reply_word_t rep_wr;
    psx_bus_pkg::port_t         next_port;
    logic                       raise_irq;

    // word each state works on.
    function automatic logic word_of(psx_state_pkg::scan_state_t s);
        case (s)
            psx_state_pkg::zero_reply,
            psx_state_pkg::shift_reply,
            psx_state_pkg::load_reply: return psx_state_pkg::word_reply;
            default:                   return psx_state_pkg::word_cmd;
        endcase
    endfunction

    ////////////////////
    // event selection
    ////////////////////

    // host requests come first, then the slot flags in packet order.
    always_comb begin
        if (req.write) begin
            next_visit = psx_state_pkg::load_reply;
        end else if (req.read) begin
            next_visit = psx_state_pkg::load_cmd;
        end else if (status.begin_flag) begin
            next_visit = psx_state_pkg::zero_count;
        end else if (status.cmd_avail) begin
            next_visit = psx_state_pkg::shift_cmd;
        end else if (status.reply_ready) begin
            next_visit = psx_state_pkg::shift_reply;
        end else begin
            next_visit = psx_state_pkg::visit;
        end
    end

    assign next_port = cur_port + 2'd1;
    assign cmd_rd    = mem_rdata;
    assign rep_rd    = mem_rdata;

    ////////////////////
    // memory and slot control
    ////////////////////

    // in visit the address is set up for the state that follows.
    // a read goes straight to the host's port, a write has already moved
    // cur_port there.
    always_comb begin
        mem_addr.port = cur_port;
        if (state == psx_state_pkg::visit && next_visit == psx_state_pkg::load_cmd) begin
            mem_addr.port = req.port;
        end
        mem_addr.word = word_of(state == psx_state_pkg::visit ? next_visit : state);
    end

    // a command bit enters at the top, the bit count carries into the index.
    always_comb begin
        cmd_wr       = cmd_rd;
        cmd_wr.shift = {status.cmd_data, cmd_rd.shift[7:1]};
        {cmd_wr.index, cmd_wr.bit_count} = {cmd_rd.index, cmd_rd.bit_count} + 1'b1;
    end

    // the stored reply moves down one bit, the zero spare bit fills the top.
    always_comb begin
        rep_wr           = '0;
        rep_wr.valid     = rep_rd.valid;
        rep_wr.bits      = {rep_rd.spare_bit, rep_rd.bits[6:1]};
    end

    always_comb begin
        mem_wr    = 1'b0;
        mem_wdata = '0;
        case (state)
            psx_state_pkg::zero_count,
            psx_state_pkg::zero_reply: mem_wr = 1'b1;
            psx_state_pkg::shift_cmd: begin
                mem_wr    = 1'b1;
                mem_wdata = cmd_wr;
            end
            psx_state_pkg::shift_reply: begin
                mem_wr    = 1'b1;
                mem_wdata = rep_wr;
            end
            psx_state_pkg::load_reply: begin
                // bit 0 goes to the slot now, bits 7 to 1 wait in memory.
                mem_wr    = 1'b1;
                mem_wdata = {7'd0, 1'b1, 1'b0, req.reply[7:1]};
            end
            default: ;
        endcase
    end

    // every slot visit clears the flags, except a pure host access.
    assign ctrl.clear = state == psx_state_pkg::visit &&
                        next_visit != psx_state_pkg::load_reply &&
                        next_visit != psx_state_pkg::load_cmd;
    assign ctrl.reply_data = (state == psx_state_pkg::load_reply) ? req.reply[0] :
                             (state == psx_state_pkg::shift_reply) ? rep_rd.bits[0] : 1'b0;
    assign ctrl.reply_strobe = (state == psx_state_pkg::load_reply) ||
                               (state == psx_state_pkg::shift_reply && rep_rd.valid);

    assign rsp.done    = state == psx_state_pkg::load_reply || state == psx_state_pkg::load_cmd;
    assign rsp.command = cmd_rd.shift;
    assign rsp.index   = cmd_rd.index;

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= psx_state_pkg::visit;
            cur_port <= '0;
        end else begin
            case (state)
                psx_state_pkg::visit: begin
                    state <= next_visit;
                    if (next_visit == psx_state_pkg::load_reply) begin
                        cur_port <= req.port;
                    end else if (next_visit == psx_state_pkg::visit) begin
                        cur_port <= next_port;
                    end
                end
                psx_state_pkg::zero_count: state <= psx_state_pkg::zero_reply;
                default: begin
                    state    <= psx_state_pkg::visit;
                    cur_port <= next_port;
                end
            endcase
        end
    end

    // a flag rises when the eighth bit is stored and falls on a host read.
    assign raise_irq = state == psx_state_pkg::shift_cmd && cmd_rd.bit_count == 3'd7;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq_flags <= '0;
        end else begin
            for (int p = 0; p < psx_bus_pkg::num_ports; p++) begin
                if (raise_irq && cur_port == psx_bus_pkg::port_t'(p)) begin
                    irq_flags[p] <= 1'b1;
                end else if (req.read && req.port == psx_bus_pkg::port_t'(p)) begin
                    irq_flags[p] <= 1'b0;
                end
            end
        end
    end

    a_state_legal : assert property (
        @(posedge clk) disable iff (reset)
        state inside {psx_state_pkg::visit, psx_state_pkg::zero_count,
                      psx_state_pkg::zero_reply, psx_state_pkg::shift_cmd,
                      psx_state_pkg::shift_reply, psx_state_pkg::load_reply,
                      psx_state_pkg::load_cmd});

    a_one_request : assert property (
        @(posedge clk) disable iff (reset) !(req.read && req.write));

endmodule

// File: psx_slot_hub.sv
// four-slot controller hub

module psx_slot_hub (
    input  logic                               clk,
    input  logic                               reset,
    input  psx_bus_pkg::slot_pins_t            pins,
    output logic [psx_bus_pkg::num_ports-1:0]  dat,
    output logic [psx_bus_pkg::num_ports-1:0]  dat_en,
    output logic [psx_bus_pkg::num_ports-1:0]  irq_flags,
    input  psx_bus_pkg::ppb_req_t              req,
    output psx_bus_pkg::ppb_rsp_t              rsp
);

    psx_bus_pkg::port_t         cur_port;
    psx_bus_pkg::ssp_ctrl_t     ctrl;
    psx_bus_pkg::ssp_status_t   status;
    psx_state_pkg::state_addr_t mem_addr;
    logic                       mem_wr;
    logic [15:0]                mem_wdata;
    logic [15:0]                mem_rdata;

    // slot front ends feed the scanner one port at a time.
    psx_slot_mux u_mux (
        .clk      (clk),
        .reset    (reset),
        .pins     (pins),
        .cur_port (cur_port),
        .ctrl     (ctrl),
        .status   (status),
        .dat      (dat),
        .dat_en   (dat_en)
    );

    psx_state_ram u_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .wr    (mem_wr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    psx_port_scanner u_scanner (
        .clk       (clk),
        .reset     (reset),
        .status    (status),
        .req       (req),
        .cur_port  (cur_port),
        .ctrl      (ctrl),
        .mem_addr  (mem_addr),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .irq_flags (irq_flags),
        .rsp       (rsp)
    );

endmodule

// File: psx_slot_mux.sv
// four slots on one serial flag bus

module psx_slot_mux (
    input  logic                                 clk,
    input  logic                                 reset,
    input  psx_bus_pkg::slot_pins_t              pins,
    input  psx_bus_pkg::port_t                   cur_port,
    input  psx_bus_pkg::ssp_ctrl_t               ctrl,
    output psx_bus_pkg::ssp_status_t             status,
    output logic [psx_bus_pkg::num_ports-1:0]    dat,
    output logic [psx_bus_pkg::num_ports-1:0]    dat_en
);

    psx_bus_pkg::ssp_status_t slot_status [psx_bus_pkg::num_ports];
    psx_bus_pkg::ssp_ctrl_t   slot_ctrl   [psx_bus_pkg::num_ports];

    // only the slot under the scanner sees clear and strobe.
    // the other slots keep their flags until their own visit.
    generate
        for (genvar i = 0; i < psx_bus_pkg::num_ports; i++) begin : g_slot
            assign slot_ctrl[i] = (cur_port == psx_bus_pkg::port_t'(i)) ? ctrl : '0;

            psx_slot_port u_port (
                .clk    (clk),
                .reset  (reset),
                .sel    (pins.sel[i]),
                .sclk   (pins.sclk[i]),
                .cmd    (pins.cmd[i]),
                .ctrl   (slot_ctrl[i]),
                .status (slot_status[i]),
                .dat    (dat[i]),
                .dat_en (dat_en[i])
            );
        end
    endgenerate

    // multiplexing while still serial leaves one copy of the byte logic.
    assign status = slot_status[cur_port];

endmodule

// File: psx_slot_port.sv
// single slot front end

module psx_slot_port (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sel,
    input  logic                     sclk,
    input  logic                     cmd,
    input  psx_bus_pkg::ssp_ctrl_t   ctrl,
    output psx_bus_pkg::ssp_status_t status,
    output logic                     dat,
    output logic                     dat_en
);

    logic [1:0] sel_sync;
    logic [1:0] sclk_sync;
    logic [1:0] cmd_sync;
    logic       sel_prev;
    logic       sclk_prev;
    logic       sel_fall;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       begin_flag;
    logic       cmd_avail;
    logic       cmd_data;
    logic       reply_ready;
    logic       reply_buf;

    ////////////////////
    // synchronizers and edge registers
    ////////////////////

    // select and clock idle high, so they come out of reset high.
    // this keeps a spurious edge from showing right after reset.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sel_sync  <= 2'b11;
            sclk_sync <= 2'b11;
            sel_prev  <= 1'b1;
            sclk_prev <= 1'b1;
        end else begin
            sel_sync  <= {sel_sync[0], sel};
            sclk_sync <= {sclk_sync[0], sclk};
            sel_prev  <= sel_sync[1];
            sclk_prev <= sclk_sync[1];
        end
    end

    // the command line travels through the same two stages as the clock.
    always_ff @(posedge clk) begin
        cmd_sync <= {cmd_sync[0], cmd};
    end

    assign sel_fall  = sel_prev & ~sel_sync[1];
    assign sclk_rise = ~sclk_prev & sclk_sync[1];
    assign sclk_fall = sclk_prev & ~sclk_sync[1];

    ////////////////////
    // sticky flags
    ////////////////////

    // a new edge wins over a clear in the same cycle, so no event is lost.
    // dat_en drops for as long as select is high.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            begin_flag  <= 1'b0;
            cmd_avail   <= 1'b0;
            reply_ready <= 1'b0;
            dat_en      <= 1'b0;
        end else begin
            if (sel_fall) begin
                begin_flag <= 1'b1;
            end else if (ctrl.clear) begin
                begin_flag <= 1'b0;
            end
            if (sclk_rise) begin
                cmd_avail <= 1'b1;
            end else if (ctrl.clear) begin
                cmd_avail <= 1'b0;
            end
            if (sclk_fall) begin
                reply_ready <= 1'b1;
            end else if (ctrl.clear) begin
                reply_ready <= 1'b0;
            end
            if (sel_sync[1]) begin
                dat_en <= 1'b0;
            end else if (ctrl.reply_strobe) begin
                dat_en <= 1'b1;
            end
        end
    end

    ////////////////////
    // data bits
    ////////////////////

    // command bit is taken on the rising clock, the buffered reply bit
    // goes out on the falling clock.
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            cmd_data <= cmd_sync[1];
        end
        if (ctrl.reply_strobe) begin
            reply_buf <= ctrl.reply_data;
        end
        if (sclk_fall) begin
            dat <= reply_buf;
        end
    end

    assign status = '{begin_flag, cmd_avail, cmd_data, reply_ready};

    // the driver must stay off between packets, whatever the scanner strobes.
    a_no_en_while_sel : assert property (
        @(posedge clk) disable iff (reset) $rose(dat_en) |-> !sel_sync[1]);

endmodule

// File: psx_slots.f
psx_bus_pkg.sv
psx_state_pkg.sv
psx_slot_port.sv
psx_slot_mux.sv
psx_state_ram.sv
psx_port_scanner.sv
psx_slot_hub.sv
tb_psx_slot_hub.sv

// File: psx_state_pkg.sv
// state memory layout and scanner states

package psx_state_pkg;

    // width of the byte index inside a packet.
    localparam int index_bits = 5;

    // one memory address, two words per port.
    typedef struct packed {
        psx_bus_pkg::port_t port;
        logic               word;
    } state_addr_t;

    // command word, index and bit_count together form one byte counter.
    typedef struct packed {
        logic [index_bits-1:0] index;
        logic [2:0]            bit_count;
        logic [7:0]            shift;
    } cmd_word_t;

    // reply word, spare_bit stays zero and feeds the top of the shifter.
    typedef struct packed {
        logic [6:0] spare;
        logic       valid;
        logic       spare_bit;
        logic [6:0] bits;
    } reply_word_t;

    // word select values.
    localparam logic word_cmd   = 1'b1;
    localparam logic word_reply = 1'b0;

    typedef enum logic [2:0] {
        visit       = 3'd0,
        zero_count  = 3'd1,
        zero_reply  = 3'd2,
        shift_cmd   = 3'd3,
        shift_reply = 3'd4,
        load_reply  = 3'd5,
        load_cmd    = 3'd6
    } scan_state_t;

endpackage

// File: psx_state_ram.sv
// per-port state memory

module psx_state_ram (
    input  logic                       clk,
    input  psx_state_pkg::state_addr_t addr,
    input  logic                       wr,
    input  logic [15:0]                wdata,
    output logic [15:0]                rdata
);

    // two words per port, command word and reply word.
    logic [15:0] mem [8];

    // read address held one cycle, so the data shows in the cycle after
    // the address was presented.
    psx_state_pkg::state_addr_t addr_q;

    ////////////////////
    // write and address register
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdata;
        end
        addr_q <= addr;
    end

    // read side is unregistered behind the address register.
    assign rdata = mem[addr_q];

endmodule

// File: tb_psx_slot_hub.sv
// testbench for the four-slot controller hub

module tb_psx_slot_hub;

    timeunit 1ns;
    timeprecision 1ps;

    // each serial half period lasts this many system cycles.
    localparam int half_period = 20;
    localparam int cycle_limit = 4000;

    logic                              clk;
    logic                              reset;
    psx_bus_pkg::slot_pins_t           pins;
    logic [psx_bus_pkg::num_ports-1:0] dat;
    logic [psx_bus_pkg::num_ports-1:0] dat_en;
    logic [psx_bus_pkg::num_ports-1:0] irq_flags;
    psx_bus_pkg::ppb_req_t             req;
    psx_bus_pkg::ppb_rsp_t             rsp;

    // expected state of each slot, kept up to date by the stimulus tasks.
    logic [7:0] exp_cmd    [4];
    logic [4:0] exp_index  [4];
    logic [7:0] reply_byte [4];
    logic [3:0] exp_dat;
    logic [3:0] reply_on;
    logic [3:0] irq_allowed;
    logic [3:0] sclk_last;
    logic [3:0] check_mask;

    integer seed;
    int     errors;
    int     cycles;
    int     bytes_sent;
    int     host_ops;

    psx_slot_hub DUT (
        .clk       (clk),
        .reset     (reset),
        .pins      (pins),
        .dat       (dat),
        .dat_en    (dat_en),
        .irq_flags (irq_flags),
        .req       (req),
        .rsp       (rsp)
    );

    always #10 clk = ~clk;

    // a rising serial clock on a slot that carries a reply marks where dat is checked.
    always @(posedge clk) sclk_last <= pins.sclk;
    assign check_mask = pins.sclk & ~sclk_last & reply_on;

    ////////////////////
    // reporting helpers
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    ////////////////////
    // checks
    ////////////////////

    // outputs are quiet in the first cycle out of reset.
    a_reset_irq : assert property (@(posedge clk) $fell(reset) |-> irq_flags == '0)
        else report_mismatch("irq_flags", 0, $sampled(irq_flags));
    a_reset_en : assert property (@(posedge clk) $fell(reset) |-> dat_en == '0)
        else report_mismatch("dat_en", 0, $sampled(dat_en));
    a_reset_done : assert property (@(posedge clk) $fell(reset) |-> !rsp.done)
        else report_mismatch("rsp.done", 0, $sampled(rsp.done));

    // a flag may only be up on a slot that has just carried a command byte.
    a_irq_expected : assert property (@(posedge clk) disable iff (reset)
        (irq_flags & ~irq_allowed) == '0)
        else report_mismatch("irq_flags", $sampled(irq_flags & irq_allowed),
                             $sampled(irq_flags));
    a_irq_rises : assert property (@(posedge clk) disable iff (reset)
        $rose(req.read) |-> irq_flags[req.port])
        else report_mismatch("irq_flags bit", 1, 0);
    a_irq_falls : assert property (@(posedge clk) disable iff (reset)
        $rose(req.read) |=> !irq_flags[req.port])
        else report_mismatch("irq_flags bit", 0, 1);

    a_done_latency : assert property (@(posedge clk) disable iff (reset)
        $rose(req.read || req.write) |-> ##[1:3] rsp.done)
        else report_failure("done did not arrive within 3 cycles of a host request");
    a_command : assert property (@(posedge clk) disable iff (reset)
        (rsp.done && req.read) |-> rsp.command == exp_cmd[req.port])
        else report_mismatch("rsp.command", exp_cmd[$sampled(req.port)],
                             $sampled(rsp.command));
    a_index : assert property (@(posedge clk) disable iff (reset)
        (rsp.done && req.read) |-> rsp.index == exp_index[req.port])
        else report_mismatch("rsp.index", exp_index[$sampled(req.port)],
                             $sampled(rsp.index));

    // reply bits are due by the rising clock that ends their low half.
    a_dat : assert property (@(posedge clk) disable iff (reset)
        ((dat ^ exp_dat) & check_mask) == '0)
        else report_mismatch("dat", $sampled(exp_dat & check_mask),
                             $sampled(dat & check_mask));
    a_dat_en : assert property (@(posedge clk) disable iff (reset)
        (~dat_en & check_mask) == '0)
        else report_mismatch("dat_en", $sampled(check_mask), $sampled(dat_en & check_mask));
    // three cycles of high select are enough for the driver to turn off.
    a_en_off : assert property (@(posedge clk) disable iff (reset)
        (pins.sel & $past(pins.sel, 3) & dat_en) == '0)
        else report_mismatch("dat_en", 0, $sampled(dat_en & pins.sel));

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic [7:0] random_byte();
        return 8'($random(seed));
    endfunction

    // waits n rising edges and returns at the drive point just after the last one.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic start_packet(input logic [3:0] ports);
        for (int p = 0; p < 4; p++) begin
            if (ports[p]) begin
                exp_index[p] = '0;
            end
        end
        pins.sel = pins.sel & ~ports;
        wait_cycles(half_period);
    endtask

    task automatic end_packet(input logic [3:0] ports);
        pins.sel = pins.sel | ports;
        wait_cycles(half_period);
    endtask

    // one byte on every slot in ports, LSB first, the command bit set up with the fall.
    task automatic send_byte(input logic [3:0] ports, input logic [3:0][7:0] data);
        irq_allowed = irq_allowed | ports;
        for (int b = 0; b < 8; b++) begin
            for (int p = 0; p < 4; p++) begin
                if (ports[p]) begin
                    exp_dat[p]  = reply_byte[p][b];
                    pins.cmd[p] = data[p][b];
                end
            end
            pins.sclk = pins.sclk & ~ports;
            wait_cycles(half_period);
            pins.sclk = pins.sclk | ports;
            wait_cycles(half_period);
        end
        for (int p = 0; p < 4; p++) begin
            if (ports[p]) begin
                exp_cmd[p]   = data[p];
                exp_index[p] = exp_index[p] + 5'd1;
            end
        end
        // a stored reply lasts for one byte.
        reply_on   = reply_on & ~ports;
        pins.cmd   = pins.cmd | ports;
        bytes_sent = bytes_sent + $countones(ports);
    endtask

    task automatic host_read(input psx_bus_pkg::port_t port);
        req.port = port;
        req.read = 1'b1;
        do begin
            wait_cycles(1);
        end while (!rsp.done);
        wait_cycles(1);
        req.read          = 1'b0;
        irq_allowed[port] = 1'b0;
        host_ops++;
    endtask

    task automatic host_write(input psx_bus_pkg::port_t port, input logic [7:0] value);
        reply_byte[port] = value;
        reply_on[port]   = 1'b1;
        req.port         = port;
        req.reply        = value;
        req.write        = 1'b1;
        do begin
            wait_cycles(1);
        end while (!rsp.done);
        wait_cycles(1);
        req.write = 1'b0;
        host_ops++;
    endtask

    // ends the run if the sequence below stalls.
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles before the tests finished", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed        = 32'h92d1;
        errors      = 0;
        bytes_sent  = 0;
        host_ops    = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        pins.sel    = '1;
        pins.sclk   = '1;
        pins.cmd    = '1;
        req         = '0;
        exp_dat     = '0;
        reply_on    = '0;
        irq_allowed = '0;
        for (int p = 0; p < 4; p++) begin
            exp_cmd[p]    = '0;
            exp_index[p]  = '0;
            reply_byte[p] = '0;
        end
        wait_cycles(8);
        reset = 1'b0;
        wait_cycles(4);

        // slot 0 takes two bytes, and the second one carries a reply.
        start_packet(4'b0001);
        send_byte(4'b0001, {24'd0, random_byte()});
        host_read(2'd0);
        host_write(2'd0, random_byte());
        send_byte(4'b0001, {24'd0, random_byte()});
        host_read(2'd0);
        end_packet(4'b0001);

        // a new packet restarts the byte index.
        start_packet(4'b0001);
        send_byte(4'b0001, {24'd0, random_byte()});
        host_read(2'd0);
        end_packet(4'b0001);

        // slots 1 and 2 clock in different bytes at the same time.
        start_packet(4'b0110);
        send_byte(4'b0110, {8'd0, random_byte(), random_byte(), 8'd0});
        host_read(2'd1);
        host_read(2'd2);
        end_packet(4'b0110);
        wait_cycles(8);

        $display("%0d bytes sent, %0d host accesses, %0d errors", bytes_sent, host_ops, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
